// File: rtl/core_types_pkg.sv
`default_nettype none

package core_types_pkg;

    // base machine word
    localparam int XLEN = 32;

    // architectural register count and index width
    localparam int NUM_REGS = 32;
    localparam int REG_ADDR_W = $clog2(NUM_REGS);

    // sequence id carried along with each instruction
    localparam int INST_ID_W = 64;

    // data or address word
    typedef logic [XLEN-1:0] word_t;

    // register index, rs1/rs2/rd
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // instruction sequence id
    typedef logic [INST_ID_W-1:0] inst_id_t;

endpackage

`default_nettype wire

// File: rtl/ctrl_pkg.sv
`default_nettype none

package ctrl_pkg;

    localparam int OP_SEL_W = 4;
    localparam int WB_SEL_W = 2;
    localparam int OPCODE_W = 7;

    typedef logic [OP_SEL_W-1:0] op_sel_t;
    typedef logic [WB_SEL_W-1:0] wb_sel_t;
    typedef logic [OPCODE_W-1:0] opcode_t;

    // op1 sources
    localparam op_sel_t OP1_RS1 = 4'd0;
    localparam op_sel_t OP1_PC  = 4'd1;
    localparam op_sel_t OP1_IMZ = 4'd2;
    localparam op_sel_t OP1_X   = 4'd3;

    // op2 sources
    localparam op_sel_t OP2_RS2W = 4'd0;
    localparam op_sel_t OP2_IMI  = 4'd1;
    localparam op_sel_t OP2_IMS  = 4'd2;
    localparam op_sel_t OP2_IMJ  = 4'd3;
    localparam op_sel_t OP2_IMU  = 4'd4;
    localparam op_sel_t OP2_X    = 4'd5;

    // write-back source
    localparam wb_sel_t WB_ALU = 2'd0;
    localparam wb_sel_t WB_MEM = 2'd1;
    localparam wb_sel_t WB_PC  = 2'd2;
    localparam wb_sel_t WB_CSR = 2'd3;

    // RV32I major opcodes
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_STORE  = 7'b0100011;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_JALR   = 7'b1100111;
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_AUIPC  = 7'b0010111;
    localparam opcode_t OPC_SYSTEM = 7'b1110011;

endpackage

`default_nettype wire

// File: rtl/fwd_if.sv
`timescale 1ns/1ns
`default_nettype none

interface fwd_if;

    import core_types_pkg::*;

    // stage holds a register-writing instruction
    logic valid;
    // result is final and may be forwarded
    logic can_forward;
    reg_addr_t addr;
    word_t wdata;

    modport src (
        output valid,
        output can_forward,
        output addr,
        output wdata
    );

    modport dst (
        input valid,
        input can_forward,
        input addr,
        input wdata
    );

endinterface

`default_nettype wire

// File: rtl/ctrl_if.sv
`timescale 1ns/1ns
`default_nettype none

interface ctrl_if;

    import core_types_pkg::*;
    import ctrl_pkg::*;

    logic ds_valid;
    word_t pc;
    word_t inst;
    inst_id_t inst_id;
    op_sel_t op1_sel;
    op_sel_t op2_sel;
    logic rf_wen;
    reg_addr_t wb_addr;
    wb_sel_t wb_sel;
    logic mem_wen;
    // immediates, already extended
    word_t imm_i;
    word_t imm_s;
    word_t imm_j;
    word_t imm_u;
    word_t imm_z;

    modport dec (
        output ds_valid, pc, inst, inst_id,
        output op1_sel, op2_sel, rf_wen, wb_addr, wb_sel, mem_wen,
        output imm_i, imm_s, imm_j, imm_u, imm_z
    );

    modport sel (
        input ds_valid, pc, inst, inst_id,
        input op1_sel, op2_sel, rf_wen, wb_addr, wb_sel, mem_wen,
        input imm_i, imm_s, imm_j, imm_u, imm_z
    );

endinterface

`default_nettype wire

// File: rtl/inst_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module inst_decoder (
    input logic clk,
    input logic reset,
    input logic stall,
    input logic fetch_valid,
    input core_types_pkg::word_t fetch_pc,
    input core_types_pkg::word_t fetch_inst,
    input core_types_pkg::inst_id_t fetch_inst_id,
    ctrl_if.dec ctrl
);

    import core_types_pkg::*;
    import ctrl_pkg::*;

    logic ds_valid_q;
    word_t pc_q;
    word_t inst_q;
    inst_id_t inst_id_q;

    opcode_t opcode;

    // decode register, frozen while stalled
    always_ff @(posedge clk) begin
        if (reset) begin
            ds_valid_q <= 1'b0;
            pc_q <= '0;
            inst_q <= '0;
            inst_id_q <= '0;
        end else if (!stall) begin
            ds_valid_q <= fetch_valid;
            pc_q <= fetch_pc;
            inst_q <= fetch_inst;
            inst_id_q <= fetch_inst_id;
        end
    end

    assign opcode = inst_q[6:0];

    assign ctrl.ds_valid = ds_valid_q;
    assign ctrl.pc = pc_q;
    assign ctrl.inst = inst_q;
    assign ctrl.inst_id = inst_id_q;
    assign ctrl.wb_addr = inst_q[11:7];

    // immediate formats
    assign ctrl.imm_i = {{20{inst_q[31]}}, inst_q[31:20]};
    assign ctrl.imm_s = {{20{inst_q[31]}}, inst_q[31:25], inst_q[11:7]};
    assign ctrl.imm_j = {{12{inst_q[31]}}, inst_q[19:12], inst_q[20], inst_q[30:21], 1'b0};
    assign ctrl.imm_u = {inst_q[31:12], 12'b0};
    // csr zimm is the rs1 field, zero extended
    assign ctrl.imm_z = {27'b0, inst_q[19:15]};

    always_comb begin
        ctrl.op1_sel = OP1_X;
        ctrl.op2_sel = OP2_X;
        ctrl.rf_wen = 1'b0;
        ctrl.wb_sel = WB_ALU;
        ctrl.mem_wen = 1'b0;
        case (opcode)
            OPC_OP: begin
                ctrl.op1_sel = OP1_RS1;
                ctrl.op2_sel = OP2_RS2W;
                ctrl.rf_wen = 1'b1;
            end
            OPC_OP_IMM: begin
                ctrl.op1_sel = OP1_RS1;
                ctrl.op2_sel = OP2_IMI;
                ctrl.rf_wen = 1'b1;
            end
            OPC_LOAD: begin
                ctrl.op1_sel = OP1_RS1;
                ctrl.op2_sel = OP2_IMI;
                ctrl.rf_wen = 1'b1;
                ctrl.wb_sel = WB_MEM;
            end
            OPC_STORE: begin
                ctrl.op1_sel = OP1_RS1;
                ctrl.op2_sel = OP2_IMS;
                ctrl.mem_wen = 1'b1;
            end
            OPC_BRANCH: begin
                ctrl.op1_sel = OP1_RS1;
                ctrl.op2_sel = OP2_RS2W;
            end
            OPC_JAL: begin
                ctrl.op1_sel = OP1_PC;
                ctrl.op2_sel = OP2_IMJ;
                ctrl.rf_wen = 1'b1;
                ctrl.wb_sel = WB_PC;
            end
            OPC_JALR: begin
                ctrl.op1_sel = OP1_RS1;
                ctrl.op2_sel = OP2_IMI;
                ctrl.rf_wen = 1'b1;
                ctrl.wb_sel = WB_PC;
            end
            OPC_LUI: begin
                ctrl.op2_sel = OP2_IMU;
                ctrl.rf_wen = 1'b1;
            end
            OPC_AUIPC: begin
                ctrl.op1_sel = OP1_PC;
                ctrl.op2_sel = OP2_IMU;
                ctrl.rf_wen = 1'b1;
            end
            OPC_SYSTEM: begin
                ctrl.op1_sel = OP1_IMZ;
                ctrl.rf_wen = 1'b1;
                ctrl.wb_sel = WB_CSR;
            end
            default: begin
                // unknown opcode writes nothing
                ctrl.rf_wen = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/reg_file.sv
`timescale 1ns/1ns
`default_nettype none

module reg_file (
    input logic clk,
    input logic reset,
    input core_types_pkg::reg_addr_t rs1_addr,
    input core_types_pkg::reg_addr_t rs2_addr,
    output core_types_pkg::word_t rs1_data,
    output core_types_pkg::word_t rs2_data,
    input logic wen,
    input core_types_pkg::reg_addr_t waddr,
    input core_types_pkg::word_t wdata
);

    import core_types_pkg::*;

    word_t regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // x0 hardwired to zero
    // same-cycle write is not bypassed here
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

`default_nettype wire

// File: rtl/data_select_stage.sv
`timescale 1ns/1ns
`default_nettype none

module data_select_stage (
    ctrl_if.sel ctrl,
    fwd_if.dst fw_exe,
    fwd_if.dst fw_mem,
    fwd_if.dst fw_wb,
    output core_types_pkg::reg_addr_t rs1_addr,
    output core_types_pkg::reg_addr_t rs2_addr,
    input core_types_pkg::word_t rf_rs1_data,
    input core_types_pkg::word_t rf_rs2_data,
    output logic stall,
    output logic exe_valid,
    output core_types_pkg::word_t exe_pc,
    output core_types_pkg::word_t exe_inst,
    output core_types_pkg::inst_id_t exe_inst_id,
    output core_types_pkg::word_t exe_op1_data,
    output core_types_pkg::word_t exe_op2_data,
    output core_types_pkg::word_t exe_rs2_data,
    output logic exe_rf_wen,
    output core_types_pkg::reg_addr_t exe_wb_addr,
    output ctrl_pkg::wb_sel_t exe_wb_sel,
    output logic exe_mem_wen
);

    import core_types_pkg::*;
    import ctrl_pkg::*;

    logic exe_rs1, exe_rs2;
    logic mem_rs1, mem_rs2;
    logic wb_rs1, wb_rs2;
    word_t rs1_data, rs2_data;

    // stage result targets this source register
    function automatic logic src_match(input logic valid, input reg_addr_t addr,
                                       input reg_addr_t rs);
        return valid && (addr == rs) && (rs != '0);
    endfunction

    assign rs1_addr = ctrl.inst[19:15];
    assign rs2_addr = ctrl.inst[24:20];

    assign exe_rs1 = src_match(fw_exe.valid, fw_exe.addr, rs1_addr);
    assign exe_rs2 = src_match(fw_exe.valid, fw_exe.addr, rs2_addr);
    assign mem_rs1 = src_match(fw_mem.valid, fw_mem.addr, rs1_addr);
    assign mem_rs2 = src_match(fw_mem.valid, fw_mem.addr, rs2_addr);
    assign wb_rs1 = src_match(fw_wb.valid, fw_wb.addr, rs1_addr);
    assign wb_rs2 = src_match(fw_wb.valid, fw_wb.addr, rs2_addr);

    // any matching stage without a final result holds us
    assign stall = ctrl.ds_valid && (
        (!fw_exe.can_forward && (exe_rs1 || exe_rs2)) ||
        (!fw_mem.can_forward && (mem_rs1 || mem_rs2)) ||
        (!fw_wb.can_forward && (wb_rs1 || wb_rs2)));

    // youngest forwardable value first, exe never supplies data
    always_comb begin
        if (rs1_addr == '0) begin
            rs1_data = '0;
        end else if (mem_rs1) begin
            rs1_data = fw_mem.wdata;
        end else if (wb_rs1) begin
            rs1_data = fw_wb.wdata;
        end else begin
            rs1_data = rf_rs1_data;
        end
    end

    always_comb begin
        if (rs2_addr == '0) begin
            rs2_data = '0;
        end else if (mem_rs2) begin
            rs2_data = fw_mem.wdata;
        end else if (wb_rs2) begin
            rs2_data = fw_wb.wdata;
        end else begin
            rs2_data = rf_rs2_data;
        end
    end

    always_comb begin
        case (ctrl.op1_sel)
            OP1_RS1: exe_op1_data = rs1_data;
            OP1_PC: exe_op1_data = ctrl.pc;
            OP1_IMZ: exe_op1_data = ctrl.imm_z;
            default: exe_op1_data = '0;
        endcase
    end

    always_comb begin
        case (ctrl.op2_sel)
            OP2_RS2W: exe_op2_data = rs2_data;
            OP2_IMI: exe_op2_data = ctrl.imm_i;
            OP2_IMS: exe_op2_data = ctrl.imm_s;
            OP2_IMJ: exe_op2_data = ctrl.imm_j;
            OP2_IMU: exe_op2_data = ctrl.imm_u;
            default: exe_op2_data = '0;
        endcase
    end

    // store data always travels on rs2
    assign exe_rs2_data = rs2_data;

    assign exe_valid = ctrl.ds_valid && !stall;
    assign exe_pc = ctrl.pc;
    assign exe_inst = ctrl.inst;
    assign exe_inst_id = ctrl.inst_id;
    assign exe_rf_wen = ctrl.rf_wen;
    assign exe_wb_addr = ctrl.wb_addr;
    assign exe_wb_sel = ctrl.wb_sel;
    assign exe_mem_wen = ctrl.mem_wen;

endmodule

`default_nettype wire

// File: rtl/operand_unit.sv
`timescale 1ns/1ns
`default_nettype none

module operand_unit (
    input logic clk,
    input logic reset,
    input logic fetch_valid,
    input core_types_pkg::word_t fetch_pc,
    input core_types_pkg::word_t fetch_inst,
    input core_types_pkg::inst_id_t fetch_inst_id,
    input logic rf_wen,
    input core_types_pkg::reg_addr_t rf_waddr,
    input core_types_pkg::word_t rf_wdata,
    input logic fwd_exe_valid,
    input logic fwd_exe_can_forward,
    input core_types_pkg::reg_addr_t fwd_exe_addr,
    input core_types_pkg::word_t fwd_exe_wdata,
    input logic fwd_mem_valid,
    input logic fwd_mem_can_forward,
    input core_types_pkg::reg_addr_t fwd_mem_addr,
    input core_types_pkg::word_t fwd_mem_wdata,
    input logic fwd_wb_valid,
    input logic fwd_wb_can_forward,
    input core_types_pkg::reg_addr_t fwd_wb_addr,
    input core_types_pkg::word_t fwd_wb_wdata,
    output logic stall,
    output logic exe_valid,
    output core_types_pkg::word_t exe_pc,
    output core_types_pkg::word_t exe_inst,
    output core_types_pkg::inst_id_t exe_inst_id,
    output core_types_pkg::word_t exe_op1_data,
    output core_types_pkg::word_t exe_op2_data,
    output core_types_pkg::word_t exe_rs2_data,
    output logic exe_rf_wen,
    output core_types_pkg::reg_addr_t exe_wb_addr,
    output ctrl_pkg::wb_sel_t exe_wb_sel,
    output logic exe_mem_wen
);

    import core_types_pkg::*;

    reg_addr_t rs1_addr, rs2_addr;
    word_t rs1_data, rs2_data;

    fwd_if fw_exe ();
    fwd_if fw_mem ();
    fwd_if fw_wb ();
    ctrl_if ctrl_bus ();

    // later-stage bundles come in as plain ports
    assign fw_exe.valid = fwd_exe_valid;
    assign fw_exe.can_forward = fwd_exe_can_forward;
    assign fw_exe.addr = fwd_exe_addr;
    assign fw_exe.wdata = fwd_exe_wdata;
    assign fw_mem.valid = fwd_mem_valid;
    assign fw_mem.can_forward = fwd_mem_can_forward;
    assign fw_mem.addr = fwd_mem_addr;
    assign fw_mem.wdata = fwd_mem_wdata;
    assign fw_wb.valid = fwd_wb_valid;
    assign fw_wb.can_forward = fwd_wb_can_forward;
    assign fw_wb.addr = fwd_wb_addr;
    assign fw_wb.wdata = fwd_wb_wdata;

    inst_decoder i_decoder (
        .clk(clk),
        .reset(reset),
        .stall(stall),
        .fetch_valid(fetch_valid),
        .fetch_pc(fetch_pc),
        .fetch_inst(fetch_inst),
        .fetch_inst_id(fetch_inst_id),
        .ctrl(ctrl_bus)
    );

    reg_file i_reg_file (
        .clk(clk),
        .reset(reset),
        .rs1_addr(rs1_addr),
        .rs2_addr(rs2_addr),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data),
        .wen(rf_wen),
        .waddr(rf_waddr),
        .wdata(rf_wdata)
    );

    data_select_stage i_data_select (
        .ctrl(ctrl_bus),
        .fw_exe(fw_exe),
        .fw_mem(fw_mem),
        .fw_wb(fw_wb),
        .rs1_addr(rs1_addr),
        .rs2_addr(rs2_addr),
        .rf_rs1_data(rs1_data),
        .rf_rs2_data(rs2_data),
        .stall(stall),
        .exe_valid(exe_valid),
        .exe_pc(exe_pc),
        .exe_inst(exe_inst),
        .exe_inst_id(exe_inst_id),
        .exe_op1_data(exe_op1_data),
        .exe_op2_data(exe_op2_data),
        .exe_rs2_data(exe_rs2_data),
        .exe_rf_wen(exe_rf_wen),
        .exe_wb_addr(exe_wb_addr),
        .exe_wb_sel(exe_wb_sel),
        .exe_mem_wen(exe_mem_wen)
    );

endmodule

`default_nettype wire

// File: verif/operand_checker.sv
`timescale 1ns/1ns
`default_nettype none

module operand_checker (
    input logic clk,
    input logic reset,
    input logic fetch_valid,
    input core_types_pkg::word_t fetch_pc,
    input core_types_pkg::word_t fetch_inst,
    input core_types_pkg::inst_id_t fetch_inst_id,
    input logic rf_wen,
    input core_types_pkg::reg_addr_t rf_waddr,
    input core_types_pkg::word_t rf_wdata,
    input logic fwd_exe_valid,
    input logic fwd_exe_can_forward,
    input core_types_pkg::reg_addr_t fwd_exe_addr,
    input logic fwd_mem_valid,
    input logic fwd_mem_can_forward,
    input core_types_pkg::reg_addr_t fwd_mem_addr,
    input core_types_pkg::word_t fwd_mem_wdata,
    input logic fwd_wb_valid,
    input logic fwd_wb_can_forward,
    input core_types_pkg::reg_addr_t fwd_wb_addr,
    input core_types_pkg::word_t fwd_wb_wdata,
    input logic stall,
    input logic exe_valid,
    input core_types_pkg::word_t exe_pc,
    input core_types_pkg::word_t exe_inst,
    input core_types_pkg::inst_id_t exe_inst_id,
    input core_types_pkg::word_t exe_op1_data,
    input core_types_pkg::word_t exe_op2_data,
    input core_types_pkg::word_t exe_rs2_data,
    input logic exe_rf_wen,
    input core_types_pkg::reg_addr_t exe_wb_addr,
    input ctrl_pkg::wb_sel_t exe_wb_sel,
    input logic exe_mem_wen,
    output int error_count,
    output int check_count,
    output int issue_count
);

    import core_types_pkg::*;
    import ctrl_pkg::*;

    // model of the decode register and the register file
    logic m_valid;
    word_t m_pc;
    word_t m_inst;
    inst_id_t m_id;
    word_t rf_model [NUM_REGS];
    inst_id_t next_issue_id = 1;
    int errors = 0;
    int checks = 0;
    int issued = 0;

    assign error_count = errors;
    assign check_count = checks;
    assign issue_count = issued;

    function automatic logic reads_reg(input reg_addr_t dest, input reg_addr_t rs1,
                                       input reg_addr_t rs2);
        return (dest != '0) && (dest == rs1 || dest == rs2);
    endfunction

    // a source that a later stage still owes
    function automatic logic expected_stall();
        logic hold;
        hold = 1'b0;
        if (fwd_exe_valid && !fwd_exe_can_forward &&
            reads_reg(fwd_exe_addr, m_inst[19:15], m_inst[24:20]))
            hold = 1'b1;
        if (fwd_mem_valid && !fwd_mem_can_forward &&
            reads_reg(fwd_mem_addr, m_inst[19:15], m_inst[24:20]))
            hold = 1'b1;
        if (fwd_wb_valid && !fwd_wb_can_forward &&
            reads_reg(fwd_wb_addr, m_inst[19:15], m_inst[24:20]))
            hold = 1'b1;
        return m_valid && hold;
    endfunction

    // newest value of a register as seen from decode
    function automatic word_t source_value(input reg_addr_t rs);
        if (rs == '0)
            return '0;
        if (fwd_mem_valid && fwd_mem_addr == rs)
            return fwd_mem_wdata;
        if (fwd_wb_valid && fwd_wb_addr == rs)
            return fwd_wb_wdata;
        return rf_model[rs];
    endfunction

    task automatic expected_controls(output word_t op1, output word_t op2, output logic wen,
                                     output wb_sel_t wb, output logic memw);
        logic signed [31:0] s;
        word_t v1, v2;
        word_t imm_i, imm_s, imm_j, imm_u, imm_z;
        v1 = source_value(m_inst[19:15]);
        v2 = source_value(m_inst[24:20]);
        s = m_inst;
        imm_i = s >>> 20;
        s = {m_inst[31:25], m_inst[11:7], 20'h0};
        imm_s = s >>> 20;
        s = {m_inst[31], m_inst[19:12], m_inst[20], m_inst[30:21], 12'h0};
        imm_j = s >>> 11;
        imm_u = {m_inst[31:12], 12'h0};
        imm_z = {27'h0, m_inst[19:15]};
        op1 = '0;
        op2 = '0;
        wen = 1'b0;
        wb = WB_ALU;
        memw = 1'b0;
        case (opcode_t'(m_inst[6:0]))
            OPC_OP: begin
                op1 = v1;
                op2 = v2;
                wen = 1'b1;
            end
            OPC_OP_IMM: begin
                op1 = v1;
                op2 = imm_i;
                wen = 1'b1;
            end
            OPC_LOAD: begin
                op1 = v1;
                op2 = imm_i;
                wen = 1'b1;
                wb = WB_MEM;
            end
            OPC_STORE: begin
                op1 = v1;
                op2 = imm_s;
                memw = 1'b1;
            end
            OPC_BRANCH: begin
                op1 = v1;
                op2 = v2;
            end
            OPC_JAL: begin
                op1 = m_pc;
                op2 = imm_j;
                wen = 1'b1;
                wb = WB_PC;
            end
            OPC_JALR: begin
                op1 = v1;
                op2 = imm_i;
                wen = 1'b1;
                wb = WB_PC;
            end
            OPC_LUI: begin
                op2 = imm_u;
                wen = 1'b1;
            end
            OPC_AUIPC: begin
                op1 = m_pc;
                op2 = imm_u;
                wen = 1'b1;
            end
            OPC_SYSTEM: begin
                op1 = imm_z;
                wen = 1'b1;
                wb = WB_CSR;
            end
            default: begin
                wen = 1'b0;
            end
        endcase
    endtask

    task automatic compare_field(input string what, input logic [63:0] got,
                                 input logic [63:0] expected);
        checks++;
        if (got !== expected) begin
            $display("** Error %0t ns: %s is 0x%0h, expected 0x%0h", $time, what, got,
                     expected);
            errors++;
        end
    endtask

    always_ff @(posedge clk) begin
        if (reset) begin
            m_valid <= 1'b0;
            m_pc <= '0;
            m_inst <= '0;
            m_id <= '0;
            for (int i = 0; i < NUM_REGS; i++) begin
                rf_model[i] <= '0;
            end
        end else begin
            if (rf_wen && rf_waddr != '0) begin
                rf_model[rf_waddr] <= rf_wdata;
            end
            if (!expected_stall()) begin
                m_valid <= fetch_valid;
                m_pc <= fetch_pc;
                m_inst <= fetch_inst;
                m_id <= fetch_inst_id;
            end
        end
    end

    // inputs settle after the rising edge, compare in the middle of the cycle
    always @(negedge clk) begin : compare
        logic hold;
        word_t op1, op2;
        logic wen, memw;
        wb_sel_t wb;
        if (!reset) begin
            hold = expected_stall();
            expected_controls(op1, op2, wen, wb, memw);
            compare_field("stall", stall, hold);
            compare_field("exe_valid", exe_valid, m_valid && !hold);
            if (m_valid) begin
                compare_field("exe_pc", exe_pc, m_pc);
                compare_field("exe_inst", exe_inst, m_inst);
                compare_field("exe_inst_id", exe_inst_id, m_id);
                compare_field("exe_op1_data", exe_op1_data, op1);
                compare_field("exe_op2_data", exe_op2_data, op2);
                compare_field("exe_rs2_data", exe_rs2_data, source_value(m_inst[24:20]));
                compare_field("exe_rf_wen", exe_rf_wen, wen);
                compare_field("exe_wb_addr", exe_wb_addr, m_inst[11:7]);
                compare_field("exe_mem_wen", exe_mem_wen, memw);
                // write-back source only matters when a register is written
                if (wen)
                    compare_field("exe_wb_sel", exe_wb_sel, wb);
            end
            if (m_valid && !hold) begin
                compare_field("issue order id", exe_inst_id, next_issue_id);
                next_issue_id = next_issue_id + 1;
                issued++;
            end
        end
    end

endmodule

`default_nettype wire

// File: verif/operand_unit_tb.sv
`timescale 1ns/1ns
`default_nettype none

module operand_unit_tb;

    import core_types_pkg::*;
    import ctrl_pkg::*;

    localparam int CLK_PERIOD = 8;
    localparam int RESET_CYCLES = 3;
    localparam int DIRECTED_CYCLES = 120;
    localparam int RANDOM_INSTS = 2000;
    localparam int WATCHDOG_NS = (RESET_CYCLES + DIRECTED_CYCLES + RANDOM_INSTS) * CLK_PERIOD * 2;

    // forwarding bundle patterns
    localparam int FWD_NONE = 0;
    localparam int FWD_RANDOM = 1;
    localparam int FWD_HOLD = 2;
    localparam int FWD_MEM_WB = 3;
    localparam int FWD_WB_ONLY = 4;
    localparam int FWD_EXE = 5;

    logic clk;
    logic reset;
    logic fetch_valid;
    word_t fetch_pc;
    word_t fetch_inst;
    inst_id_t fetch_inst_id;
    logic rf_wen;
    reg_addr_t rf_waddr;
    word_t rf_wdata;
    logic fwd_exe_valid;
    logic fwd_exe_can_forward;
    reg_addr_t fwd_exe_addr;
    word_t fwd_exe_wdata;
    logic fwd_mem_valid;
    logic fwd_mem_can_forward;
    reg_addr_t fwd_mem_addr;
    word_t fwd_mem_wdata;
    logic fwd_wb_valid;
    logic fwd_wb_can_forward;
    reg_addr_t fwd_wb_addr;
    word_t fwd_wb_wdata;
    logic stall;
    logic exe_valid;
    word_t exe_pc;
    word_t exe_inst;
    inst_id_t exe_inst_id;
    word_t exe_op1_data;
    word_t exe_op2_data;
    word_t exe_rs2_data;
    logic exe_rf_wen;
    reg_addr_t exe_wb_addr;
    wb_sel_t exe_wb_sel;
    logic exe_mem_wen;
    int error_count;
    int check_count;
    int issue_count;

    logic [31:0] rng_state = 32'd76;
    word_t pc_next = 32'h0000_1000;
    inst_id_t next_id = 1;
    logic allow_writes = 1'b0;
    reg_addr_t focus_reg = '0;
    int test_num = 0;
    int errors_at_start = 0;
    int checks_at_start = 0;
    int tb_errors = 0;

    operand_unit i_dut (.*);

    operand_checker i_checker (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog: run timed out after %0d ns without finishing the tests", WATCHDOG_NS);
        $display("Simulation failed");
        $finish;
    end

    function automatic logic [31:0] xorshift();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // mostly x0..x7 so that hazards come up often
    function automatic reg_addr_t biased_reg();
        logic [31:0] r;
        r = xorshift();
        if (r[3:0] < 4'd12)
            return {2'b00, r[6:4]};
        return r[11:7];
    endfunction

    function automatic opcode_t opcode_at(input int k);
        case (k)
            0: return OPC_OP;
            1: return OPC_OP_IMM;
            2: return OPC_LOAD;
            3: return OPC_STORE;
            4: return OPC_BRANCH;
            5: return OPC_JAL;
            6: return OPC_JALR;
            7: return OPC_LUI;
            8: return OPC_AUIPC;
            9: return OPC_SYSTEM;
            default: return 7'b1111111;
        endcase
    endfunction

    function automatic word_t encode(input opcode_t opc, input reg_addr_t rd,
                                     input reg_addr_t rs1, input reg_addr_t rs2,
                                     input logic [9:0] funct);
        return {funct[9:3], rs2, rs1, funct[2:0], rd, opc};
    endfunction

    function automatic word_t random_inst(input opcode_t opc);
        reg_addr_t rd, rs1, rs2;
        logic [31:0] r;
        rd = biased_reg();
        rs1 = biased_reg();
        rs2 = biased_reg();
        r = xorshift();
        return encode(opc, rd, rs1, rs2, r[9:0]);
    endfunction

    task automatic drive_forwarding(input int mode);
        logic [31:0] r;
        r = xorshift();
        fwd_exe_valid <= 1'b0;
        fwd_mem_valid <= 1'b0;
        fwd_wb_valid <= 1'b0;
        fwd_exe_can_forward <= 1'b1;
        fwd_mem_can_forward <= 1'b1;
        fwd_wb_can_forward <= 1'b1;
        fwd_exe_addr <= biased_reg();
        fwd_mem_addr <= biased_reg();
        fwd_wb_addr <= biased_reg();
        fwd_exe_wdata <= xorshift();
        fwd_mem_wdata <= xorshift();
        fwd_wb_wdata <= xorshift();
        case (mode)
            FWD_RANDOM: begin
                fwd_exe_valid <= r[0];
                fwd_mem_valid <= r[1];
                fwd_wb_valid <= r[2];
                fwd_exe_can_forward <= r[5:3] != 3'd0;
                fwd_mem_can_forward <= r[8:6] != 3'd0;
                fwd_wb_can_forward <= r[11:9] != 3'd0;
            end
            FWD_HOLD: begin
                fwd_exe_valid <= 1'b1;
                fwd_exe_addr <= focus_reg;
                fwd_exe_can_forward <= 1'b0;
            end
            FWD_MEM_WB: begin
                fwd_mem_valid <= 1'b1;
                fwd_mem_addr <= focus_reg;
                fwd_wb_valid <= 1'b1;
                fwd_wb_addr <= focus_reg;
            end
            FWD_WB_ONLY: begin
                fwd_wb_valid <= 1'b1;
                fwd_wb_addr <= focus_reg;
            end
            FWD_EXE: begin
                fwd_exe_valid <= 1'b1;
                fwd_exe_addr <= focus_reg;
            end
            default: begin
            end
        endcase
    endtask

    // the fetch inputs only move on when the decode register took the last ones
    task automatic drive_cycle(input logic fv, input word_t inst, input int mode,
                               output logic taken);
        logic [31:0] r;
        @(posedge clk);
        taken = !stall;
        if (taken) begin
            fetch_valid <= fv;
            fetch_inst <= inst;
            fetch_pc <= pc_next;
            fetch_inst_id <= next_id;
            pc_next = pc_next + 32'd4;
            if (fv)
                next_id = next_id + 1;
        end
        r = xorshift();
        rf_wen <= allow_writes && r[0];
        rf_waddr <= biased_reg();
        rf_wdata <= xorshift();
        drive_forwarding(mode);
    endtask

    task automatic issue(input logic fv, input word_t inst, input int mode);
        logic taken;
        taken = 1'b0;
        while (!taken) begin
            drive_cycle(fv, inst, mode, taken);
        end
    endtask

    task automatic end_test(input string name);
        test_num++;
        $display("test %0d %s: %0d checks, %0d errors", test_num, name,
                 check_count - checks_at_start, error_count + tb_errors - errors_at_start);
        checks_at_start = check_count;
        errors_at_start = error_count + tb_errors;
    endtask

    initial begin
        logic taken;
        logic [31:0] r;
        inst_id_t start_id;
        word_t inst;
        reset <= 1'b1;
        fetch_valid <= 1'b0;
        fetch_pc <= '0;
        fetch_inst <= '0;
        fetch_inst_id <= '0;
        rf_wen <= 1'b0;
        rf_waddr <= '0;
        rf_wdata <= '0;
        drive_forwarding(FWD_NONE);
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;

        // every register reads zero before any write
        repeat (2) issue(1'b0, '0, FWD_NONE);
        for (int k = 0; k < NUM_REGS; k++) begin
            issue(1'b1, encode(OPC_OP, 5'd1, reg_addr_t'(k), reg_addr_t'(31 - k), '0),
                  FWD_NONE);
        end
        end_test("reset and unwritten registers");

        allow_writes = 1'b1;
        repeat (16) issue(1'b0, '0, FWD_NONE);
        for (int k = 0; k < 11; k++) begin
            repeat (2) issue(1'b1, random_inst(opcode_at(k)), FWD_NONE);
        end
        end_test("decode of each opcode");

        focus_reg = 5'd4;
        inst = encode(OPC_OP, 5'd9, focus_reg, focus_reg, '0);
        issue(1'b1, inst, FWD_NONE);
        repeat (4) issue(1'b1, inst, FWD_MEM_WB);
        repeat (4) issue(1'b1, inst, FWD_WB_ONLY);
        repeat (4) issue(1'b1, inst, FWD_EXE);
        end_test("forwarding priority");

        // x5 owed by exe for four cycles
        focus_reg = 5'd5;
        issue(1'b1, encode(OPC_OP, 5'd3, 5'd5, 5'd6, '0), FWD_NONE);
        issue(1'b1, random_inst(OPC_OP_IMM), FWD_HOLD);
        repeat (3) drive_cycle(1'b0, '0, FWD_HOLD, taken);
        issue(1'b1, random_inst(OPC_LOAD), FWD_NONE);
        repeat (2) issue(1'b0, '0, FWD_NONE);
        end_test("stall and hold");

        start_id = next_id;
        while (next_id - start_id < RANDOM_INSTS) begin
            r = xorshift();
            issue(r[2:0] != 3'd0, random_inst(opcode_at(r[31:8] % 11)), FWD_RANDOM);
        end
        repeat (4) issue(1'b0, '0, FWD_NONE);
        if (issue_count != next_id - 1) begin
            $display("instruction count mismatch: %0d reached execute, %0d were fetched",
                     issue_count, next_id - 1);
            tb_errors++;
        end
        end_test("random mixed run");

        $display("%0d tests, %0d checks, %0d errors", test_num, check_count,
                 error_count + tb_errors);
        if (error_count == 0 && tb_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
rtl/core_types_pkg.sv
rtl/ctrl_pkg.sv
rtl/fwd_if.sv
rtl/ctrl_if.sv
rtl/inst_decoder.sv
rtl/reg_file.sv
rtl/data_select_stage.sv
rtl/operand_unit.sv
verif/operand_checker.sv
verif/operand_unit_tb.sv

// File: Bender.yml
package:
  name: operand_unit

sources:
  - files:
      - rtl/core_types_pkg.sv
      - rtl/ctrl_pkg.sv
      - rtl/fwd_if.sv
      - rtl/ctrl_if.sv
      - rtl/inst_decoder.sv
      - rtl/reg_file.sv
      - rtl/data_select_stage.sv
      - rtl/operand_unit.sv
  - target: test
    files:
      - verif/operand_checker.sv
      - verif/operand_unit_tb.sv
